/* command_decoder.sv */
// Command decoder that queues moves, holds the enable mask and builds status replies
`timescale 1ns/10ps
`include "stepper_config.svh"

module command_decoder
  import stepper_pkg::*;
(
  input  logic                                buffered_clk,
  input  logic                                resetn,
  input  logic                                halt,
  input  logic [`WORD_BITS-1:0]               word_rx,
  input  logic                                word_valid,
  input  logic                                wr_ack,
  input  logic                                wr_dropped,
  input  logic [`MOTOR_COUNT*LEVEL_BITS-1:0]  queue_level,
  input  logic [`MOTOR_COUNT-1:0]             idle,
  output logic                                wr_req,
  output logic [MOTOR_BITS-1:0]               wr_motor,
  output move_t                               wr_move,
  output status_t                             word_tx,
  output logic [`MOTOR_COUNT-1:0]             enable_mask,
  output logic                                buffer_dtr,
  output logic                                move_done
);

  typedef enum logic [1:0] {WR_IDLE, WR_REQ, WR_RELEASE} wr_state_e;

  wr_state_e  wr_state;
  opcode_e    opcode;
  logic [7:0] motor_idx;
  logic       move_ok;
  logic       overflow;  // Sticky until the next STATUS
  logic       all_free;
  logic       all_empty;
  status_t    snapshot;

  assign opcode    = opcode_e'(word_rx[63:56]);
  assign motor_idx = word_rx[55:48];
  assign move_ok   = (motor_idx < 8'(`MOTOR_COUNT)) && !halt && (wr_state == WR_IDLE);

  always_comb begin
    all_free  = 1'b1;
    all_empty = 1'b1;
    for (int m = 0; m < `MOTOR_COUNT; m++) begin
      if (queue_level[m*LEVEL_BITS +: LEVEL_BITS] >= LEVEL_BITS'(`QUEUE_DEPTH))
        all_free = 1'b0;
      if (queue_level[m*LEVEL_BITS +: LEVEL_BITS] != '0)
        all_empty = 1'b0;
    end
  end

  always_comb begin
    snapshot             = '0;
    snapshot.signature   = STATUS_SIGNATURE;
    snapshot.enable_mask = enable_mask;
    snapshot.overflow    = overflow;
    snapshot.buffer_dtr  = buffer_dtr;
    snapshot.move_done   = move_done;
    snapshot.queue_level = queue_level;
  end

  always_ff @(posedge buffered_clk) begin
    if (!resetn) begin
      wr_state    <= WR_IDLE;
      wr_req      <= 1'b0;
      enable_mask <= '0;
      overflow    <= 1'b0;
      word_tx     <= '0;
      buffer_dtr  <= 1'b0;
      move_done   <= 1'b0;
    end else begin
      buffer_dtr <= all_free && (wr_state == WR_IDLE) && !wr_req;
      move_done  <= all_empty && (&idle);
      if (word_valid) begin
        case (opcode)
          OP_MOVE: begin
            if (move_ok) begin
              wr_req   <= 1'b1;
              wr_state <= WR_REQ;
            end
          end
          OP_ENABLE: enable_mask <= word_rx[`MOTOR_COUNT-1:0];
          OP_STATUS: begin
            word_tx  <= snapshot;  // Shifted out with the next word
            overflow <= 1'b0;
          end
          default: ;
        endcase
      end
      // Four-phase write toward the move store
      case (wr_state)
        WR_REQ: begin
          if (wr_ack) begin
            wr_req   <= 1'b0;
            wr_state <= WR_RELEASE;
            if (wr_dropped)
              overflow <= 1'b1;  // Queue was full
          end
        end
        WR_RELEASE: begin
          if (!wr_ack)
            wr_state <= WR_IDLE;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge buffered_clk) begin
    if (word_valid && opcode == OP_MOVE && move_ok) begin
      wr_motor         <= motor_idx[MOTOR_BITS-1:0];
      wr_move.dir      <= word_rx[47];
      wr_move.steps    <= word_rx[31:16];
      wr_move.duration <= word_rx[15:0];
    end
  end

endmodule

/* move_store.sv */
// Shared move memory with per-motor rings behind a round-robin four-phase arbiter
`timescale 1ns/10ps
`include "stepper_config.svh"

module move_store
  import stepper_pkg::*;
(
  input  logic                                buffered_clk,
  input  logic                                resetn,
  input  logic                                flush,
  input  logic                                wr_req,
  input  logic [MOTOR_BITS-1:0]               wr_motor,
  input  move_t                               wr_move,
  output logic                                wr_ack,
  output logic                                wr_dropped,
  input  logic [`MOTOR_COUNT-1:0]             rd_req,
  output logic [`MOTOR_COUNT-1:0]             rd_ack,
  output move_t                               rd_move,
  output logic [`MOTOR_COUNT*LEVEL_BITS-1:0]  queue_level
);

  localparam int REQ_COUNT  = `MOTOR_COUNT + 1;  // Readers, then the writer
  localparam int WR_PORT    = `MOTOR_COUNT;
  localparam int GRANT_BITS = $clog2(REQ_COUNT);
  localparam int PTR_BITS   = $clog2(`QUEUE_DEPTH);
  localparam int ADDR_BITS  = $clog2(`MOTOR_COUNT * `QUEUE_DEPTH);

  typedef enum logic [1:0] {ARB_IDLE, ARB_SERVE, ARB_RELEASE} arb_state_e;

  move_t                  mem [`MOTOR_COUNT*`QUEUE_DEPTH];
  logic [PTR_BITS-1:0]    head [`MOTOR_COUNT];
  logic [PTR_BITS-1:0]    tail [`MOTOR_COUNT];
  logic [LEVEL_BITS-1:0]  level [`MOTOR_COUNT];
  arb_state_e             state;
  logic [REQ_COUNT-1:0]   req;
  logic [REQ_COUNT-1:0]   eligible;
  logic [REQ_COUNT-1:0]   ack;
  logic [GRANT_BITS-1:0]  grant;  // Also the last one served
  logic [GRANT_BITS-1:0]  pick;
  logic                   pick_valid;
  logic                   serve_write;
  logic [MOTOR_BITS-1:0]  serve_motor;
  logic                   serve_full;
  logic                   do_write;
  logic                   do_read;
  logic [ADDR_BITS-1:0]   addr;

  assign req    = {wr_req, rd_req};
  assign rd_ack = ack[`MOTOR_COUNT-1:0];
  assign wr_ack = ack[WR_PORT];

  // Reads wait until their queue holds an entry
  always_comb begin
    for (int m = 0; m < `MOTOR_COUNT; m++) begin
      eligible[m] = rd_req[m] && (level[m] != '0) && !flush;
      queue_level[m*LEVEL_BITS +: LEVEL_BITS] = level[m];
    end
    eligible[WR_PORT] = wr_req;
  end

  // First eligible requester after the last one served
  always_comb begin
    int idx;
    pick       = grant;
    pick_valid = 1'b0;
    for (int k = 1; k <= REQ_COUNT; k++) begin
      idx = int'(grant) + k;
      if (idx >= REQ_COUNT)
        idx = idx - REQ_COUNT;
      if (!pick_valid && eligible[idx]) begin
        pick       = GRANT_BITS'(idx);
        pick_valid = 1'b1;
      end
    end
  end

  assign serve_write = (grant == GRANT_BITS'(WR_PORT));
  assign serve_motor = serve_write ? wr_motor : grant[MOTOR_BITS-1:0];
  assign serve_full  = (level[serve_motor] == LEVEL_BITS'(`QUEUE_DEPTH));
  assign do_write    = (state == ARB_SERVE) && serve_write && !flush && !serve_full;
  assign do_read     = (state == ARB_SERVE) && !serve_write && (level[serve_motor] != '0);
  assign addr = ADDR_BITS'(serve_motor) * ADDR_BITS'(`QUEUE_DEPTH)
              + ADDR_BITS'(serve_write ? tail[serve_motor] : head[serve_motor]);

  always_ff @(posedge buffered_clk) begin
    if (!resetn) begin
      state      <= ARB_IDLE;
      grant      <= '0;
      ack        <= '0;
      wr_dropped <= 1'b0;
      for (int m = 0; m < `MOTOR_COUNT; m++) begin
        head[m]  <= '0;
        tail[m]  <= '0;
        level[m] <= '0;
      end
    end else begin
      case (state)
        ARB_IDLE: begin
          if (pick_valid) begin
            grant <= pick;
            state <= ARB_SERVE;
          end
        end
        ARB_SERVE: begin
          ack[grant] <= 1'b1;
          state      <= ARB_RELEASE;
          if (serve_write)
            wr_dropped <= serve_full && !flush;  // Acked but not stored
          if (do_write) begin
            tail[serve_motor]  <= tail[serve_motor] + 1'b1;
            level[serve_motor] <= level[serve_motor] + 1'b1;
          end
          if (do_read) begin
            head[serve_motor]  <= head[serve_motor] + 1'b1;
            level[serve_motor] <= level[serve_motor] - 1'b1;
          end
        end
        ARB_RELEASE: begin
          if (!req[grant]) begin
            ack   <= '0;
            state <= ARB_IDLE;
          end
        end
        default: state <= ARB_IDLE;
      endcase
      if (flush) begin
        for (int m = 0; m < `MOTOR_COUNT; m++) begin
          head[m]  <= '0;
          tail[m]  <= '0;
          level[m] <= '0;
        end
      end
    end
  end

  always_ff @(posedge buffered_clk) begin
    if (do_write)
      mem[addr] <= wr_move;
    if (do_read)
      rd_move <= mem[addr];  // Held while ack is high
  end

endmodule

/* run_sim.sh */
#!/bin/sh
# Builds the stepper_core testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --top-module tb_stepper_core -f stepper_core.f -o tb_stepper_core
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_stepper_core > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
  exit 1
fi
exit 0

/* spi_word.sv */
// SPI mode-0 target that assembles received words and shifts out reply words
`timescale 1ns/10ps
`include "stepper_config.svh"

module spi_word (
  input  logic                   buffered_clk,
  input  logic                   resetn,
  input  logic                   sck,
  input  logic                   cs_n,
  input  logic                   copi,
  input  logic [`WORD_BITS-1:0]  word_tx,
  output logic                   cipo,
  output logic [`WORD_BITS-1:0]  word_rx,
  output logic                   word_valid
);

  localparam int COUNT_BITS = $clog2(`WORD_BITS);
  localparam logic [COUNT_BITS-1:0] LAST_BIT = COUNT_BITS'(`WORD_BITS - 1);

  logic [2:0]             sck_sync;  // Two sync stages plus edge history
  logic [2:0]             cs_sync;
  logic [1:0]             copi_sync;
  logic                   selected;
  logic                   sck_rise;
  logic                   sck_fall;
  logic                   cs_start;
  logic [COUNT_BITS-1:0]  bit_count;
  logic [`WORD_BITS-1:0]  rx_shift;
  logic [`WORD_BITS-1:0]  tx_shift;

  always_ff @(posedge buffered_clk) begin
    if (!resetn) begin
      sck_sync  <= '0;
      cs_sync   <= '1;
      copi_sync <= '0;
    end else begin
      sck_sync  <= {sck_sync[1:0], sck};
      cs_sync   <= {cs_sync[1:0], cs_n};
      copi_sync <= {copi_sync[0], copi};
    end
  end

  assign selected = !cs_sync[1];
  assign sck_rise = selected && sck_sync[1] && !sck_sync[2];
  assign sck_fall = selected && !sck_sync[1] && sck_sync[2];
  assign cs_start = !cs_sync[1] && cs_sync[2];  // Falling chip select

  always_ff @(posedge buffered_clk) begin
    if (!resetn) begin
      bit_count  <= '0;
      word_valid <= 1'b0;
    end else begin
      word_valid <= 1'b0;
      if (!selected) begin
        bit_count <= '0;
      end else if (sck_rise) begin
        bit_count  <= bit_count + 1'b1;  // Wraps to zero after the last bit
        word_valid <= (bit_count == LAST_BIT);
      end
    end
  end

  // MSB first
  always_ff @(posedge buffered_clk) begin
    if (sck_rise) begin
      rx_shift <= {rx_shift[`WORD_BITS-2:0], copi_sync[1]};
      if (bit_count == LAST_BIT)
        word_rx <= {rx_shift[`WORD_BITS-2:0], copi_sync[1]};
    end
  end

  // Reply changes on falling SCK so the host samples it on the next rise
  always_ff @(posedge buffered_clk) begin
    if (!resetn) begin
      tx_shift <= '0;
    end else if (cs_start) begin
      tx_shift <= word_tx;
    end else if (sck_fall) begin
      if (bit_count == '0)
        tx_shift <= word_tx;  // Back-to-back word boundary
      else
        tx_shift <= {tx_shift[`WORD_BITS-2:0], 1'b0};
    end
  end

  assign cipo = tx_shift[`WORD_BITS-1];

endmodule

/* step_generator.sv */
// Per-motor engine that fetches moves and spreads their steps with a DDA accumulator
`timescale 1ns/10ps
`include "stepper_config.svh"

module step_generator
  import stepper_pkg::*;
(
  input  logic   buffered_clk,
  input  logic   resetn,
  input  logic   halt,
  input  logic   enable,
  output logic   rd_req,
  input  logic   rd_ack,
  input  move_t  rd_move,
  output logic   step,
  output logic   dir,
  output logic   idle
);

  typedef enum logic [2:0] {
    GEN_IDLE,
    GEN_FETCH,
    GEN_CANCEL1,  // Request withdrawn, a grant may still be in flight
    GEN_CANCEL2,
    GEN_RELEASE,
    GEN_RUN
  } gen_state_e;

  gen_state_e   state;
  logic [15:0]  steps_q;
  logic [15:0]  duration_q;
  logic [15:0]  cycles_left;
  logic [16:0]  acc;
  logic [16:0]  acc_sum;
  logic         step_q;
  logic         take_move;

  assign take_move = rd_ack && (state inside {GEN_FETCH, GEN_CANCEL1, GEN_CANCEL2});
  assign acc_sum   = acc + {1'b0, steps_q};
  assign step      = step_q && !halt;
  assign idle      = !rd_ack && (state inside {GEN_IDLE, GEN_FETCH, GEN_CANCEL1, GEN_CANCEL2});

  always_ff @(posedge buffered_clk) begin
    if (!resetn) begin
      state       <= GEN_IDLE;
      rd_req      <= 1'b0;
      step_q      <= 1'b0;
      dir         <= 1'b0;
      acc         <= '0;
      cycles_left <= '0;
    end else begin
      step_q <= 1'b0;
      if (take_move) begin
        rd_req <= 1'b0;
        dir    <= rd_move.dir;  // Settles before the first pulse
        state  <= GEN_RELEASE;
      end else begin
        case (state)
          GEN_IDLE: begin
            if (enable && !halt && !rd_ack) begin
              rd_req <= 1'b1;
              state  <= GEN_FETCH;
            end
          end
          GEN_FETCH: begin
            if (!enable) begin
              rd_req <= 1'b0;
              state  <= GEN_CANCEL1;
            end
          end
          GEN_CANCEL1: state <= GEN_CANCEL2;
          GEN_CANCEL2: state <= GEN_IDLE;
          GEN_RELEASE: begin
            if (!rd_ack) begin
              acc         <= '0;
              cycles_left <= duration_q;
              state       <= (duration_q == '0) ? GEN_IDLE : GEN_RUN;
            end
          end
          GEN_RUN: begin
            if (enable) begin  // Frozen while disabled
              if (acc_sum >= {1'b0, duration_q}) begin
                step_q <= 1'b1;
                acc    <= acc_sum - {1'b0, duration_q};
              end else begin
                acc <= acc_sum;
              end
              cycles_left <= cycles_left - 1'b1;
              if (cycles_left == 16'd1)
                state <= GEN_IDLE;
            end
          end
          default: state <= GEN_IDLE;
        endcase
      end
      if (halt) begin
        state  <= GEN_IDLE;
        rd_req <= 1'b0;
        step_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge buffered_clk) begin
    if (take_move) begin
      steps_q    <= rd_move.steps;
      duration_q <= rd_move.duration;
    end
  end

endmodule

/* stepper_config.svh */
// Build sizing for the two-axis stepper motion controller
`ifndef STEPPER_CONFIG_SVH
`define STEPPER_CONFIG_SVH

// Number of step/dir/enable channels
`define MOTOR_COUNT 2

// Moves held per motor queue
`define QUEUE_DEPTH 4

// SPI word width in bits
`define WORD_BITS 64

// Core reset is held until this counter saturates
`define RESET_STRETCH_BITS 8

`endif

/* stepper_core.f */
+incdir+.
stepper_pkg.sv
spi_word.sv
command_decoder.sv
move_store.sv
step_generator.sv
stepper_core.sv
tb_clock_gen.sv
tb_stepper_core.sv

/* stepper_core.sv */
// Two-axis stepper controller top with SPI command link and stretched core reset
`timescale 1ns/10ps
`include "stepper_config.svh"

module stepper_core
  import stepper_pkg::*;
(
  input  logic                     clk,
  input  logic                     resetn,
  input  logic                     sck,
  input  logic                     cs_n,
  input  logic                     copi,
  input  logic                     halt,
  output logic                     cipo,
  output logic [`MOTOR_COUNT-1:0]  step,
  output logic [`MOTOR_COUNT-1:0]  dir,
  output logic [`MOTOR_COUNT-1:0]  enable,
  output logic                     buffer_dtr,
  output logic                     move_done
);

  logic                                buffered_clk;
  logic [`RESET_STRETCH_BITS-1:0]      reset_count;
  logic                                core_resetn;
  logic [`WORD_BITS-1:0]               word_rx;
  logic                                word_valid;
  status_t                             word_tx;
  logic                                wr_req;
  logic                                wr_ack;
  logic                                wr_dropped;
  logic [MOTOR_BITS-1:0]               wr_motor;
  move_t                               wr_move;
  move_t                               rd_move;
  logic [`MOTOR_COUNT-1:0]             rd_req;
  logic [`MOTOR_COUNT-1:0]             rd_ack;
  logic [`MOTOR_COUNT-1:0]             idle;
  logic [`MOTOR_COUNT*LEVEL_BITS-1:0]  queue_level;

  assign buffered_clk = clk;

  // Core leaves reset once the counter saturates
  assign core_resetn = &reset_count;

  always_ff @(posedge buffered_clk) begin
    if (!resetn)
      reset_count <= '0;
    else if (!core_resetn)
      reset_count <= reset_count + 1'b1;
  end

  spi_word u_spi (
    .buffered_clk (buffered_clk),
    .resetn       (core_resetn),
    .sck          (sck),
    .cs_n         (cs_n),
    .copi         (copi),
    .word_tx      (word_tx),
    .cipo         (cipo),
    .word_rx      (word_rx),
    .word_valid   (word_valid)
  );

  command_decoder u_decoder (
    .buffered_clk (buffered_clk),
    .resetn       (core_resetn),
    .halt         (halt),
    .word_rx      (word_rx),
    .word_valid   (word_valid),
    .wr_ack       (wr_ack),
    .wr_dropped   (wr_dropped),
    .queue_level  (queue_level),
    .idle         (idle),
    .wr_req       (wr_req),
    .wr_motor     (wr_motor),
    .wr_move      (wr_move),
    .word_tx      (word_tx),
    .enable_mask  (enable),
    .buffer_dtr   (buffer_dtr),
    .move_done    (move_done)
  );

  move_store u_store (
    .buffered_clk (buffered_clk),
    .resetn       (core_resetn),
    .flush        (halt),
    .wr_req       (wr_req),
    .wr_motor     (wr_motor),
    .wr_move      (wr_move),
    .wr_ack       (wr_ack),
    .wr_dropped   (wr_dropped),
    .rd_req       (rd_req),
    .rd_ack       (rd_ack),
    .rd_move      (rd_move),
    .queue_level  (queue_level)
  );

  for (genvar i = 0; i < `MOTOR_COUNT; i++) begin : g_motor
    step_generator u_gen (
      .buffered_clk (buffered_clk),
      .resetn       (core_resetn),
      .halt         (halt),
      .enable       (enable[i]),
      .rd_req       (rd_req[i]),
      .rd_ack       (rd_ack[i]),
      .rd_move      (rd_move),  // Shared, qualified by this motor's ack
      .step         (step[i]),
      .dir          (dir[i]),
      .idle         (idle[i])
    );
  end

endmodule

/* stepper_pkg.sv */
// Opcode, move record and status reply types for the stepper controller
`include "stepper_config.svh"

package stepper_pkg;

  localparam int MOTOR_BITS = (`MOTOR_COUNT > 1) ? $clog2(`MOTOR_COUNT) : 1;
  localparam int LEVEL_BITS = $clog2(`QUEUE_DEPTH) + 1;  // Counts 0..QUEUE_DEPTH
  localparam int STATUS_PAD_BITS = `WORD_BITS - 8 - `MOTOR_COUNT - 3
                                   - `MOTOR_COUNT * LEVEL_BITS;
  localparam logic [7:0] STATUS_SIGNATURE = 8'hA5;

  // Command code in word bits 63..56
  typedef enum logic [7:0] {
    OP_NOP    = 8'h00,
    OP_MOVE   = 8'h01,
    OP_STATUS = 8'h02,
    OP_ENABLE = 8'h03
  } opcode_e;

  typedef struct packed {
    logic        dir;
    logic [15:0] steps;
    logic [15:0] duration;  // Clock cycles
  } move_t;

  typedef struct packed {
    logic [7:0]                          signature;
    logic [STATUS_PAD_BITS-1:0]          pad;
    logic [`MOTOR_COUNT-1:0]             enable_mask;
    logic                                overflow;
    logic                                buffer_dtr;
    logic                                move_done;
    logic [`MOTOR_COUNT*LEVEL_BITS-1:0]  queue_level;  // Motor 0 in the low bits
  } status_t;

endpackage

/* tb_clock_gen.sv */
// Testbench clock and reset source for the stepper controller
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int HALF_PERIOD  = 4,  // 8 ns clock
  parameter int RESET_CYCLES = 10
) (
  output logic clk,
  output logic resetn
);

  initial clk = 1'b0;
  always #(HALF_PERIOD) clk = ~clk;

  initial begin
    resetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    resetn <= 1'b1;
  end

endmodule

/* tb_stepper_core.sv */
// Testbench for the stepper controller with SPI stimulus and a queue model
`timescale 1ns/10ps
`include "stepper_config.svh"

module tb_stepper_core
  import stepper_pkg::*;
();

  localparam int MC           = `MOTOR_COUNT;
  localparam int SPI_HALF     = 5;  // Clocks per SCK half-period
  localparam int SPI_GAP      = 6;
  localparam int WORD_CYCLES  = 2 * SPI_HALF * `WORD_BITS + SPI_HALF + SPI_GAP + 4;
  localparam int WORD_COUNT   = 41;
  localparam int RANDOM_MOVES = 12;
  localparam int MAX_DUR      = 80;
  localparam int HALT_DUR     = 3000;
  localparam int MOVE_CYCLES  = (RANDOM_MOVES + 2 + `QUEUE_DEPTH + 1) * MAX_DUR + 3 * HALT_DUR;
  localparam int WATCHDOG_CYCLES = 2 * (WORD_COUNT * WORD_CYCLES + MOVE_CYCLES + 600);

  logic           clk;
  logic           resetn;
  logic           sck;
  logic           cs_n;
  logic           copi;
  logic           halt;
  logic           cipo;
  logic [MC-1:0]  step;
  logic [MC-1:0]  dir;
  logic [MC-1:0]  enable;
  logic           buffer_dtr;
  logic           move_done;

  int  seed = 18908;
  int  errors;
  int  checks;
  int  pulses [MC];      // Observed step pulses
  int  exp_pulses [MC];  // Sum of accepted move steps
  bit  last_dir [MC];
  int  remain_q [MC][$];  // Model queue, steps left per move
  bit  dir_q [MC][$];

  tb_clock_gen u_clock (.clk(clk), .resetn(resetn));

  stepper_core dut (
    .clk        (clk),
    .resetn     (resetn),
    .sck        (sck),
    .cs_n       (cs_n),
    .copi       (copi),
    .halt       (halt),
    .cipo       (cipo),
    .step       (step),
    .dir        (dir),
    .enable     (enable),
    .buffer_dtr (buffer_dtr),
    .move_done  (move_done)
  );

  function automatic int rand_range(input int lo, input int hi);
    int r;
    r = $random(seed) & 32'h7fff_ffff;
    return lo + (r % (hi - lo + 1));
  endfunction

  function automatic bit model_empty();
    for (int m = 0; m < MC; m++)
      if (remain_q[m].size() != 0)
        return 1'b0;
    return 1'b1;
  endfunction

  // Expected reply; a disabled motor still holds every queued move
  function automatic status_t model_status(input logic [MC-1:0] mask, input logic ovf,
                                           input logic dtr, input logic done);
    status_t s;
    s             = '0;
    s.signature   = 8'hA5;
    s.enable_mask = mask;
    s.overflow    = ovf;
    s.buffer_dtr  = dtr;
    s.move_done   = done;
    for (int m = 0; m < MC; m++)
      if (!mask[m])
        s.queue_level[m*LEVEL_BITS +: LEVEL_BITS] = LEVEL_BITS'(remain_q[m].size());
    return s;
  endfunction

  task automatic check_status(input status_t got, input status_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s status %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_steps(input int motor, input int got_count, input int exp_count,
                             input logic got_dir, input logic exp_dir);
    checks++;
    if (got_count != exp_count) begin
      errors++;
      $display("ERR %0t: motor %0d gave %0d pulses, expected %0d",
               $time, motor, got_count, exp_count);
    end
    if (got_dir !== exp_dir) begin
      errors++;
      $display("ERR %0t: motor %0d dir %b, expected %b", $time, motor, got_dir, exp_dir);
    end
  endtask

  task automatic check_enable(input logic [MC-1:0] got, input logic [MC-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: enable pins %b, expected %b", $time, got, exp);
    end
  endtask

  task automatic check_reset_outputs();
    checks++;
    if ({step, dir, enable, buffer_dtr, move_done, cipo} !== '0) begin
      errors++;
      $display("ERR %0t: outputs active during core reset step=%b dir=%b en=%b dtr=%b done=%b",
               $time, step, dir, enable, buffer_dtr, move_done);
    end
  endtask

  // Mode 0, MSB first; reply bit read as SCK rises
  task automatic spi_transfer(input logic [`WORD_BITS-1:0] tx,
                              output logic [`WORD_BITS-1:0] rx);
    rx = '0;
    @(posedge clk);
    cs_n <= 1'b0;
    copi <= tx[`WORD_BITS-1];
    repeat (SPI_HALF + 2) @(posedge clk);
    for (int b = `WORD_BITS - 1; b >= 0; b--) begin
      sck   <= 1'b1;
      rx[b] = cipo;
      repeat (SPI_HALF) @(posedge clk);
      sck <= 1'b0;
      if (b > 0)
        copi <= tx[b-1];
      repeat (SPI_HALF) @(posedge clk);
    end
    cs_n <= 1'b1;
    repeat (SPI_GAP) @(posedge clk);
  endtask

  task automatic send_enable(input logic [MC-1:0] mask);
    logic [`WORD_BITS-1:0] rx;
    spi_transfer({8'(OP_ENABLE), (`WORD_BITS - 8 - MC)'(0), mask}, rx);
    check_enable(enable, mask);
  endtask

  // Model entry goes in first since pulses can start before the task returns
  task automatic send_move(input int motor, input logic d, input int steps, input int dur,
                           input bit kept);
    logic [`WORD_BITS-1:0] rx;
    if (kept) begin
      remain_q[motor].push_back(steps);
      dir_q[motor].push_back(d);
      exp_pulses[motor] += steps;
    end
    spi_transfer({8'(OP_MOVE), 8'(motor), d, 15'h0, 16'(steps), 16'(dur)}, rx);
  endtask

  task automatic read_status(output status_t st);
    logic [`WORD_BITS-1:0] rx;
    spi_transfer({8'(OP_STATUS), 56'h0}, rx);
    spi_transfer('0, rx);  // NOP carries the reply
    st = status_t'(rx);
  endtask

  task automatic wait_moves_done();
    repeat (8) @(posedge clk);
    while (!(model_empty() && move_done === 1'b1))
      @(posedge clk);
  endtask

  task automatic check_all_steps();
    for (int m = 0; m < MC; m++)
      check_steps(m, pulses[m], exp_pulses[m], dir[m], last_dir[m]);
  endtask

  // Pulse monitor against the model queues
  always @(posedge clk) begin
    int r;
    for (int m = 0; m < MC; m++) begin
      if (halt) begin
        if (step[m])
          check_steps(m, 1, 0, dir[m], dir[m]);  // Pulse during halt
        remain_q[m].delete();
        dir_q[m].delete();
      end else if (step[m]) begin
        pulses[m]++;
        if (remain_q[m].size() == 0) begin
          check_steps(m, 1, 0, dir[m], last_dir[m]);
        end else begin
          check_steps(m, 1, 1, dir[m], dir_q[m][0]);
          last_dir[m] = dir_q[m][0];
          r = remain_q[m].pop_front() - 1;
          if (r > 0)
            remain_q[m].push_front(r);
          else
            void'(dir_q[m].pop_front());
        end
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    status_t st;
    int      base;
    int      steps;
    sck  = 1'b0;
    cs_n = 1'b1;
    copi = 1'b0;
    halt = 1'b0;
    wait (resetn === 1'b1);
    repeat (240) begin  // Still inside the stretched core reset
      @(posedge clk);
      check_reset_outputs();
    end
    while (buffer_dtr !== 1'b1)
      @(posedge clk);

    read_status(st);
    check_status(st, model_status('0, 1'b0, 1'b1, 1'b1), "after reset");

    // Random moves, paced by buffer_dtr
    send_enable(2'b11);
    for (int i = 0; i < RANDOM_MOVES; i++) begin
      while (buffer_dtr !== 1'b1)
        @(posedge clk);
      steps = rand_range(1, 20);
      send_move(rand_range(0, MC - 1), 1'($random(seed)), steps,
                rand_range(steps, MAX_DUR), 1'b1);
    end
    wait_moves_done();
    check_all_steps();
    read_status(st);
    check_status(st, model_status(2'b11, 1'b0, 1'b1, 1'b1), "random moves done");

    // Disabled motor keeps its moves queued
    send_enable(2'b01);
    base = pulses[1];
    for (int i = 0; i < 2; i++) begin
      steps = rand_range(1, 20);
      send_move(1, 1'($random(seed)), steps, rand_range(steps, MAX_DUR), 1'b1);
    end
    read_status(st);
    check_status(st, model_status(2'b01, 1'b0, 1'b1, 1'b0), "motor 1 disabled");
    check_steps(1, pulses[1] - base, 0, dir[1], last_dir[1]);
    send_enable(2'b11);
    wait_moves_done();
    check_all_steps();

    // One move more than the queue holds
    send_enable(2'b01);
    for (int i = 0; i <= `QUEUE_DEPTH; i++) begin
      steps = rand_range(1, 20);
      send_move(1, 1'($random(seed)), steps, rand_range(steps, MAX_DUR), i < `QUEUE_DEPTH);
    end
    read_status(st);
    check_status(st, model_status(2'b01, 1'b1, 1'b0, 1'b0), "queue overflow");
    send_enable(2'b11);
    wait_moves_done();
    check_all_steps();
    read_status(st);
    check_status(st, model_status(2'b11, 1'b0, 1'b1, 1'b1), "overflow cleared");

    // Long moves cut short by halt
    base = pulses[0];
    send_move(0, 1'b1, 30, HALT_DUR, 1'b1);
    send_move(1, 1'b0, 30, HALT_DUR, 1'b1);
    send_move(0, 1'b0, 30, HALT_DUR, 1'b1);
    while (pulses[0] == base)
      @(posedge clk);
    @(posedge clk);
    halt <= 1'b1;
    repeat (4) @(posedge clk);
    halt <= 1'b0;
    repeat (8) @(posedge clk);
    read_status(st);
    check_status(st, model_status(2'b11, 1'b0, 1'b1, 1'b1), "after halt");

    $display("Summary: %0d checks, %0d errors, pulses m0=%0d m1=%0d",
             checks, errors, pulses[0], pulses[1]);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule
